// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [15:0] word_t;
    // counts 32-bit instruction words
    typedef logic [15:0] pc_t;
    typedef logic [3:0] reg_idx_t;
    // bit 4 marks a jump, bits 3:0 pick the condition
    typedef logic [4:0] jump_code_t;

    typedef enum logic [6:0] {
        OPC_NOP = 7'h00,
        OPC_MOV = 7'h01,
        OPC_LDI = 7'h04,
        OPC_ADD = 7'h07,
        OPC_ADI = 7'h08,
        OPC_ADC = 7'h09,
        OPC_SUB = 7'h0a,
        OPC_SUC = 7'h0b,
        OPC_CMP = 7'h0c,
        OPC_CMI = 7'h0d,
        OPC_JMP = 7'h0e,
        OPC_JAL = 7'h0f,
        OPC_AND = 7'h13,
        OPC_ORR = 7'h14,
        OPC_XOR = 7'h15,
        OPC_ANI = 7'h16,
        OPC_ORI = 7'h17,
        OPC_XOI = 7'h18,
        OPC_SHL = 7'h19,
        OPC_SHR = 7'h1a,
        OPC_CAI = 7'h1b,
        OPC_SLI = 7'h23,
        OPC_SRI = 7'h24,
        OPC_SAR = 7'h25,
        OPC_SAI = 7'h26,
        OPC_SEX = 7'h27
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_L_PASS,
        ALU_R_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR,
        ALU_ASHR,
        ALU_SEXT
    } alu_mode_t;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
        logic v;
    } flags_t;

    // instr_l is bus data 15:0, imm is bus data 31:16
    typedef struct packed {
        logic [15:0] instr_l;
        word_t       imm;
        pc_t         pc;
    } fetch_pkt_t;

    typedef struct packed {
        alu_mode_t  alu_mode;
        logic       r_bus_imm;
        logic       carry_en;
        logic       flags_ie;
        reg_idx_t   l_sel;
        reg_idx_t   r_sel;
        reg_idx_t   rd;
        logic       rf_we;
        jump_code_t jump_code;
        logic       jal;
        logic [1:0] used_operands;
        word_t      imm;
        pc_t        pc;
    } ctrl_t;

    typedef struct packed {
        pc_t      pc;
        logic     rf_we;
        reg_idx_t rd;
        word_t    value;
        flags_t   flags;
        logic     jump_taken;
    } retire_t;

endpackage

`default_nettype wire

// File: src/alu.sv
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_mode_t i_mode,
    input  wire cpu_pkg::word_t     i_l,
    input  wire cpu_pkg::word_t     i_r,
    input  wire                     i_carry_in,
    input  wire                     i_carry_en,
    output cpu_pkg::word_t          o_result,
    output cpu_pkg::flags_t         o_flags
);

    logic       cin;
    logic       carry;
    logic       ovf;
    logic [3:0] shamt;

    assign cin = i_carry_en && i_carry_in;
    assign shamt = i_r[3:0];

    always_comb begin
        carry = 1'b0;
        ovf = 1'b0;
        case (i_mode)
            cpu_pkg::ALU_R_PASS: o_result = i_r;
            cpu_pkg::ALU_ADD: begin
                {carry, o_result} = {1'b0, i_l} + {1'b0, i_r} + 17'(cin);
                ovf = (i_l[15] == i_r[15]) && (o_result[15] != i_l[15]);
            end
            // carry out is the borrow
            cpu_pkg::ALU_SUB: begin
                {carry, o_result} = {1'b0, i_l} - {1'b0, i_r} - 17'(cin);
                ovf = (i_l[15] != i_r[15]) && (o_result[15] != i_l[15]);
            end
            cpu_pkg::ALU_AND: o_result = i_l & i_r;
            cpu_pkg::ALU_OR: o_result = i_l | i_r;
            cpu_pkg::ALU_XOR: o_result = i_l ^ i_r;
            cpu_pkg::ALU_SHL: o_result = i_l << shamt;
            cpu_pkg::ALU_SHR: o_result = i_l >> shamt;
            cpu_pkg::ALU_ASHR: o_result = cpu_pkg::word_t'($signed(i_l) >>> shamt);
            cpu_pkg::ALU_SEXT: o_result = {{8{i_l[7]}}, i_l[7:0]};
            default: o_result = i_l;
        endcase
    end

    assign o_flags = '{z: (o_result == '0), c: carry, n: o_result[15], v: ovf};

endmodule

`default_nettype wire

// File: src/reg_file.sv
`default_nettype none

module reg_file #(
    parameter int REG_COUNT = 16
) (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire cpu_pkg::reg_idx_t  i_rd_a,
    input  wire cpu_pkg::reg_idx_t  i_rd_b,
    input  wire                     i_we,
    input  wire cpu_pkg::reg_idx_t  i_wr_idx,
    input  wire cpu_pkg::word_t     i_wr_data,
    output cpu_pkg::word_t          o_a,
    output cpu_pkg::word_t          o_b
);

    cpu_pkg::word_t regs [REG_COUNT];

    assign o_a = regs[i_rd_a];
    assign o_b = regs[i_rd_b];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

endmodule

`default_nettype wire

// File: fetch/fetch.sv
`default_nettype none

module fetch (
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  wire [31:0]          i_wb_dat,
    input  wire                 i_wb_ack,
    input  wire                 i_ready,
    input  wire                 i_flush,
    input  wire cpu_pkg::pc_t   i_redirect_pc,
    output logic                o_wb_cyc,
    output logic                o_wb_stb,
    output cpu_pkg::pc_t        o_wb_adr,
    output cpu_pkg::fetch_pkt_t o_pkt,
    output logic                o_submit
);

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DROP
    } state_t;

    state_t       state;
    cpu_pkg::pc_t pc;
    logic         pkt_valid;
    logic         start;
    logic         take_word;

    // held packet counts as taken once decode shows ready
    assign start = (state == IDLE) && (!pkt_valid || i_ready) && !i_flush;
    assign take_word = (state == BUS) && i_wb_ack && !i_flush;

    assign o_wb_cyc = (state != IDLE);
    assign o_wb_stb = (state != IDLE);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= IDLE;
            pc <= '0;
            pkt_valid <= 1'b0;
            o_submit <= 1'b0;
        end else begin
            o_submit <= take_word;
            if (pkt_valid && i_ready) begin
                pkt_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= BUS;
                    end
                end
                BUS: begin
                    if (i_wb_ack) begin
                        state <= IDLE;
                    end else if (i_flush) begin
                        state <= DROP;
                    end
                    if (take_word) begin
                        pc <= pc + 16'd1;
                        pkt_valid <= 1'b1;
                    end
                end
                // stale cycle still open, wait out its ack
                DROP: begin
                    if (i_wb_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (i_flush) begin
                pc <= i_redirect_pc;
                pkt_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            o_wb_adr <= pc;
        end
        if (take_word) begin
            o_pkt.instr_l <= i_wb_dat[15:0];
            o_pkt.imm <= i_wb_dat[31:16];
            o_pkt.pc <= o_wb_adr;
        end
    end

endmodule

`default_nettype wire

// File: decode/decode.sv
`default_nettype none

module decode (
    input  wire                      i_clk,
    input  wire                      i_rst,
    input  wire cpu_pkg::fetch_pkt_t i_pkt,
    input  wire                      i_submit,
    input  wire                      i_next_ready,
    input  wire                      i_flush,
    output logic                     o_ready,
    output logic                     o_submit,
    output cpu_pkg::ctrl_t           o_ctrl
);

    cpu_pkg::opcode_t  op;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::reg_idx_t rs1;
    cpu_pkg::reg_idx_t rs2;
    cpu_pkg::ctrl_t    c;
    logic              input_valid;
    logic              take;

    assign op = cpu_pkg::opcode_t'(i_pkt.instr_l[6:0]);
    assign rd = i_pkt.instr_l[10:7];
    assign rs1 = i_pkt.instr_l[14:11];
    // second source lives in the immediate half
    assign rs2 = i_pkt.imm[3:0];

    function automatic cpu_pkg::alu_mode_t mode_of(input cpu_pkg::opcode_t opc);
        case (opc)
            cpu_pkg::OPC_ADD, cpu_pkg::OPC_ADI, cpu_pkg::OPC_ADC: return cpu_pkg::ALU_ADD;
            cpu_pkg::OPC_SUB, cpu_pkg::OPC_SUC,
            cpu_pkg::OPC_CMP, cpu_pkg::OPC_CMI: return cpu_pkg::ALU_SUB;
            cpu_pkg::OPC_AND, cpu_pkg::OPC_ANI, cpu_pkg::OPC_CAI: return cpu_pkg::ALU_AND;
            cpu_pkg::OPC_ORR, cpu_pkg::OPC_ORI: return cpu_pkg::ALU_OR;
            cpu_pkg::OPC_XOR, cpu_pkg::OPC_XOI: return cpu_pkg::ALU_XOR;
            cpu_pkg::OPC_SHL, cpu_pkg::OPC_SLI: return cpu_pkg::ALU_SHL;
            cpu_pkg::OPC_SHR, cpu_pkg::OPC_SRI: return cpu_pkg::ALU_SHR;
            cpu_pkg::OPC_SAR, cpu_pkg::OPC_SAI: return cpu_pkg::ALU_ASHR;
            cpu_pkg::OPC_SEX: return cpu_pkg::ALU_SEXT;
            cpu_pkg::OPC_LDI, cpu_pkg::OPC_JMP, cpu_pkg::OPC_JAL: return cpu_pkg::ALU_R_PASS;
            default: return cpu_pkg::ALU_L_PASS;
        endcase
    endfunction

    always_comb begin
        c = '0;
        c.alu_mode = mode_of(op);
        c.imm = i_pkt.imm;
        c.pc = i_pkt.pc;
        case (op)
            cpu_pkg::OPC_MOV, cpu_pkg::OPC_SEX: begin
                c.l_sel = rs1;
                c.rd = rd;
                c.rf_we = 1'b1;
                c.used_operands = 2'b01;
                c.flags_ie = (op == cpu_pkg::OPC_SEX);
            end
            cpu_pkg::OPC_LDI: begin
                c.r_bus_imm = 1'b1;
                c.rd = rd;
                c.rf_we = 1'b1;
            end
            cpu_pkg::OPC_ADD, cpu_pkg::OPC_ADC, cpu_pkg::OPC_SUB, cpu_pkg::OPC_SUC,
            cpu_pkg::OPC_CMP, cpu_pkg::OPC_AND, cpu_pkg::OPC_ORR, cpu_pkg::OPC_XOR,
            cpu_pkg::OPC_SHL, cpu_pkg::OPC_SHR, cpu_pkg::OPC_SAR: begin
                c.l_sel = rs1;
                c.r_sel = rs2;
                c.rd = rd;
                c.used_operands = 2'b11;
                c.flags_ie = 1'b1;
                c.rf_we = (op != cpu_pkg::OPC_CMP);
                c.carry_en = (op == cpu_pkg::OPC_ADC) || (op == cpu_pkg::OPC_SUC);
            end
            cpu_pkg::OPC_ADI, cpu_pkg::OPC_CMI, cpu_pkg::OPC_ANI, cpu_pkg::OPC_ORI,
            cpu_pkg::OPC_XOI, cpu_pkg::OPC_CAI, cpu_pkg::OPC_SLI, cpu_pkg::OPC_SRI,
            cpu_pkg::OPC_SAI: begin
                c.l_sel = rs1;
                c.r_bus_imm = 1'b1;
                c.rd = rd;
                c.used_operands = 2'b01;
                c.flags_ie = 1'b1;
                c.rf_we = (op != cpu_pkg::OPC_CMI) && (op != cpu_pkg::OPC_CAI);
            end
            // condition code sits in the rd field
            cpu_pkg::OPC_JMP: begin
                c.r_bus_imm = 1'b1;
                c.jump_code = {1'b1, rd};
            end
            cpu_pkg::OPC_JAL: begin
                c.r_bus_imm = 1'b1;
                c.rd = rd;
                c.rf_we = 1'b1;
                c.jal = 1'b1;
                c.jump_code = 5'b10000;
            end
            // nop and unused opcodes keep the zero word
            default: begin
            end
        endcase
    end

    assign o_ready = i_next_ready && !input_valid;
    assign take = i_next_ready && (i_submit || input_valid) && !i_flush;

    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush) begin
            o_submit <= 1'b0;
            input_valid <= 1'b0;
        end else begin
            o_submit <= take;
            if (i_next_ready) begin
                input_valid <= 1'b0;
            end else if (i_submit) begin
                input_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            o_ctrl <= c;
        end
    end

    flush_blocks_submit: assert property (
        @(posedge i_clk) disable iff (i_rst) i_flush |=> !o_submit
    );

endmodule

`default_nettype wire

// File: execute/execute.sv
`default_nettype none

module execute #(
    parameter int REG_COUNT = 16
) (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire cpu_pkg::ctrl_t  i_ctrl,
    input  wire                  i_submit,
    input  wire                  i_retire_ready,
    output logic                 o_ready,
    output cpu_pkg::retire_t     o_retire,
    output logic                 o_retire_valid,
    output logic                 o_flush,
    output cpu_pkg::pc_t         o_redirect_pc
);

    cpu_pkg::flags_t flags;
    cpu_pkg::flags_t alu_flags;
    cpu_pkg::flags_t next_flags;
    cpu_pkg::word_t  rf_a;
    cpu_pkg::word_t  rf_b;
    cpu_pkg::word_t  l_op;
    cpu_pkg::word_t  r_op;
    cpu_pkg::word_t  alu_result;
    cpu_pkg::word_t  wr_value;
    logic            held;
    logic            can_load;
    logic            accept;
    logic            cond_met;
    logic            taken;

    assign can_load = !o_retire_valid || i_retire_ready;
    assign o_ready = can_load && !held;
    // younger work arriving with the flush is dropped
    assign accept = can_load && (i_submit || held) && !o_flush;

    reg_file #(
        .REG_COUNT(REG_COUNT)
    ) reg_file_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rd_a    (i_ctrl.l_sel),
        .i_rd_b    (i_ctrl.r_sel),
        .i_we      (accept && i_ctrl.rf_we),
        .i_wr_idx  (i_ctrl.rd),
        .i_wr_data (wr_value),
        .o_a       (rf_a),
        .o_b       (rf_b)
    );

    // operands the opcode does not use read as zero
    assign l_op = i_ctrl.used_operands[0] ? rf_a : '0;
    assign r_op = i_ctrl.r_bus_imm ? i_ctrl.imm : (i_ctrl.used_operands[1] ? rf_b : '0);

    alu alu_i (
        .i_mode     (i_ctrl.alu_mode),
        .i_l        (l_op),
        .i_r        (r_op),
        .i_carry_in (flags.c),
        .i_carry_en (i_ctrl.carry_en),
        .o_result   (alu_result),
        .o_flags    (alu_flags)
    );

    assign wr_value = i_ctrl.jal ? cpu_pkg::word_t'(i_ctrl.pc + 16'd1) : alu_result;
    assign next_flags = i_ctrl.flags_ie ? alu_flags : flags;

    always_comb begin
        case (i_ctrl.jump_code[3:0])
            4'd0: cond_met = 1'b1;
            4'd1: cond_met = flags.z;
            4'd2: cond_met = !flags.z;
            4'd3: cond_met = flags.c;
            4'd4: cond_met = !flags.c;
            4'd5: cond_met = flags.n;
            4'd6: cond_met = !flags.n;
            4'd7: cond_met = flags.v;
            default: cond_met = 1'b0;
        endcase
    end

    assign taken = i_ctrl.jump_code[4] && cond_met;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flags <= '0;
            held <= 1'b0;
            o_retire_valid <= 1'b0;
            o_flush <= 1'b0;
        end else begin
            o_flush <= accept && taken;
            held <= !o_flush && !can_load && (held || i_submit);
            if (accept) begin
                flags <= next_flags;
                o_retire_valid <= 1'b1;
            end else if (i_retire_ready) begin
                o_retire_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_retire.pc <= i_ctrl.pc;
            o_retire.rf_we <= i_ctrl.rf_we;
            o_retire.rd <= i_ctrl.rd;
            o_retire.value <= wr_value;
            o_retire.flags <= next_flags;
            o_retire.jump_taken <= taken;
            o_redirect_pc <= i_ctrl.imm;
        end
    end

    flush_single_cycle: assert property (
        @(posedge i_clk) disable iff (i_rst) o_flush |=> !o_flush
    );

    retire_stable: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_retire_valid && !i_retire_ready |=> o_retire_valid && $stable(o_retire)
    );

endmodule

`default_nettype wire

// File: src/cpu_core.sv
`default_nettype none

module cpu_core #(
    parameter int REG_COUNT = 16
) (
    input  wire                i_clk,
    input  wire                i_rst,
    output logic               o_wb_cyc,
    output logic               o_wb_stb,
    output cpu_pkg::pc_t       o_wb_adr,
    input  wire [31:0]         i_wb_dat,
    input  wire                i_wb_ack,
    input  wire                i_retire_ready,
    output cpu_pkg::retire_t   o_retire,
    output logic               o_retire_valid
);

    // instruction bus is read only, so no we line
    cpu_pkg::fetch_pkt_t fetch_pkt;
    cpu_pkg::ctrl_t      ctrl;
    cpu_pkg::pc_t        redirect_pc;
    logic                fetch_submit;
    logic                decode_ready;
    logic                decode_submit;
    logic                exec_ready;
    logic                flush;

    fetch fetch_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack),
        .i_ready       (decode_ready),
        .i_flush       (flush),
        .i_redirect_pc (redirect_pc),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .o_wb_adr      (o_wb_adr),
        .o_pkt         (fetch_pkt),
        .o_submit      (fetch_submit)
    );

    decode decode_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_pkt        (fetch_pkt),
        .i_submit     (fetch_submit),
        .i_next_ready (exec_ready),
        .i_flush      (flush),
        .o_ready      (decode_ready),
        .o_submit     (decode_submit),
        .o_ctrl       (ctrl)
    );

    execute #(
        .REG_COUNT(REG_COUNT)
    ) execute_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_ctrl         (ctrl),
        .i_submit       (decode_submit),
        .i_retire_ready (i_retire_ready),
        .o_ready        (exec_ready),
        .o_retire       (o_retire),
        .o_retire_valid (o_retire_valid),
        .o_flush        (flush),
        .o_redirect_pc  (redirect_pc)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_checker.sv
`default_nettype none

module tb_checker #(
    parameter int EXP_MAX = 64,
    parameter int TIMEOUT = 400
) (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_wb_cyc,
    input  wire                     i_wb_stb,
    input  wire cpu_pkg::pc_t       i_wb_adr,
    input  wire                     i_wb_ack,
    input  wire                     i_retire_ready,
    input  wire                     i_retire_valid,
    input  wire cpu_pkg::retire_t   i_retire,
    input  wire cpu_pkg::retire_t   i_exp [EXP_MAX],
    input  var int                  i_exp_test [EXP_MAX],
    input  var int                  i_exp_count,
    output logic                    o_done,
    output int                      o_errors,
    output int                      o_test
);

    timeunit 1ns;
    timeprecision 100ps;

    logic seen_cyc;
    logic seen_ack;
    int   start_errors;

    // first bus cycle must read address 0, nothing retires before the first ack
    always @(negedge i_clk) begin
        if (i_rst) begin
            seen_cyc <= 1'b0;
            seen_ack <= 1'b0;
            start_errors <= 0;
        end else begin
            if (i_wb_cyc && i_wb_stb && !seen_cyc) begin
                seen_cyc <= 1'b1;
                if (i_wb_adr != '0) begin
                    $display("ERROR at %0t: first fetch address is %h, not 0", $time, i_wb_adr);
                    start_errors <= start_errors + 1;
                end
            end
            if (i_wb_ack) begin
                seen_ack <= 1'b1;
            end
            if (i_retire_valid && !seen_ack) begin
                $display("ERROR at %0t: retire seen before the first bus ack", $time);
                start_errors <= start_errors + 1;
            end
        end
    end

    initial begin
        int idx;
        int waited;
        int test_errs;
        int total_errs;
        int tests_run;
        int tests_failed;
        logic hs;
        logic timed_out;
        o_done = 1'b0;
        o_errors = 0;
        o_test = 0;
        idx = 0;
        test_errs = 0;
        total_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        waited = 0;
        while (i_rst !== 1'b0 && waited < TIMEOUT) begin
            @(negedge i_clk);
            waited++;
        end
        if (i_rst !== 1'b0) begin
            $display("reset was never released");
            timed_out = 1'b1;
            total_errs++;
        end
        o_test = i_exp_test[0];
        while (idx < i_exp_count && !timed_out) begin
            waited = 0;
            hs = 1'b0;
            while (!hs && waited < TIMEOUT) begin
                @(negedge i_clk);
                waited++;
                hs = i_retire_valid && i_retire_ready;
            end
            if (!hs) begin
                $display("no retire arrived for record %0d of test %0d within %0d cycles",
                         idx, o_test, TIMEOUT);
                timed_out = 1'b1;
                test_errs++;
            end else begin
                if (i_retire !== i_exp[idx]) begin
                    $write("ERROR at %0t: test %0d record %0d got pc=%h we=%b rd=%0d ",
                           $time, o_test, idx, i_retire.pc, i_retire.rf_we, i_retire.rd);
                    $display("val=%h fl=%b jt=%b",
                             i_retire.value, i_retire.flags, i_retire.jump_taken);
                    $display("ERROR at %0t: expected pc=%h we=%b rd=%0d val=%h fl=%b jt=%b",
                             $time, i_exp[idx].pc, i_exp[idx].rf_we, i_exp[idx].rd,
                             i_exp[idx].value, i_exp[idx].flags, i_exp[idx].jump_taken);
                    test_errs++;
                end
                idx++;
            end
            if (timed_out || idx == i_exp_count || i_exp_test[idx] != o_test) begin
                $display("test %0d: %s, %0d errors", o_test, (test_errs == 0) ? "ok" : "failed",
                         test_errs);
                tests_run++;
                if (test_errs != 0) begin
                    tests_failed++;
                end
                total_errs += test_errs;
                test_errs = 0;
                if (idx < i_exp_count) begin
                    o_test = i_exp_test[idx];
                end
            end
        end
        total_errs += start_errors;
        $display("tests run %0d, failed %0d, records checked %0d, errors %0d",
                 tests_run, tests_failed, idx, total_errs);
        o_errors = total_errs;
        o_done = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_cpu_core.sv
`default_nettype none

module tb_cpu_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int EXP_MAX   = 64;
    localparam int MEM_WORDS = 256;
    localparam int RUN_LIMIT = 20000;

    logic                clk;
    logic                rst;
    logic                wb_cyc;
    logic                wb_stb;
    cpu_pkg::pc_t        wb_adr;
    logic [31:0]         wb_dat;
    logic                wb_ack;
    logic                retire_ready;
    cpu_pkg::retire_t    retire;
    logic                retire_valid;
    logic [31:0]         mem [MEM_WORDS];
    cpu_pkg::retire_t    exp_rec [EXP_MAX];
    int                  exp_test [EXP_MAX];
    int                  exp_count;
    int                  seed;
    int                  wait_left;
    logic                chk_done;
    int                  chk_errors;
    int                  cur_test;

    tb_clock #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (5)
    ) tb_clock_i (
        .o_clk (clk),
        .o_rst (rst)
    );

    cpu_core #(
        .REG_COUNT (16)
    ) cpu_core_i (
        .i_clk          (clk),
        .i_rst          (rst),
        .o_wb_cyc       (wb_cyc),
        .o_wb_stb       (wb_stb),
        .o_wb_adr       (wb_adr),
        .i_wb_dat       (wb_dat),
        .i_wb_ack       (wb_ack),
        .i_retire_ready (retire_ready),
        .o_retire       (retire),
        .o_retire_valid (retire_valid)
    );

    tb_checker #(
        .EXP_MAX (EXP_MAX)
    ) tb_checker_i (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_wb_cyc       (wb_cyc),
        .i_wb_stb       (wb_stb),
        .i_wb_adr       (wb_adr),
        .i_wb_ack       (wb_ack),
        .i_retire_ready (retire_ready),
        .i_retire_valid (retire_valid),
        .i_retire       (retire),
        .i_exp          (exp_rec),
        .i_exp_test     (exp_test),
        .i_exp_count    (exp_count),
        .o_done         (chk_done),
        .o_errors       (chk_errors),
        .o_test         (cur_test)
    );

    // instruction memory with 0 to 3 wait cycles, plus retire back-pressure in test 5
    always @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            retire_ready <= 1'b1;
        end else begin
            if (wb_ack) begin
                wb_ack <= 1'b0;
                wait_left <= $unsigned($random(seed)) % 4;
            end else if (wb_cyc && wb_stb) begin
                if (wait_left == 0) begin
                    wb_ack <= 1'b1;
                    wb_dat <= mem[wb_adr[7:0]];
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
            if (cur_test == 5) begin
                retire_ready <= (($random(seed) & 1) != 0);
            end else begin
                retire_ready <= 1'b1;
            end
        end
    end

    initial begin
        int          fd;
        int          cycles;
        int          t;
        string       line;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] we;
        logic [31:0] rd;
        logic [31:0] fl;
        logic [31:0] jt;
        seed = 32'h5495e04b;
        wait_left = 0;
        wb_dat = '0;
        wb_ack = 1'b0;
        retire_ready = 1'b1;
        exp_count = 0;
        // unknown opcode 0x7f acts as a nop, imm carries the address
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {16'(i), 16'h007f};
        end
        fd = $fopen("testbench/cpu_stimulus.mem", "r");
        if (fd == 0) begin
            $display("could not open testbench/cpu_stimulus.mem");
            $display("SIMULATION FAILED");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] == "P") begin
                    if ($sscanf(line, "P %h %h", a, w) == 2) begin
                        mem[a[7:0]] = w;
                    end
                end else if (line.len() > 0 && line[0] == "E" && exp_count < EXP_MAX) begin
                    if ($sscanf(line, "E %d %h %h %h %h %h %h",
                                t, a, we, rd, w, fl, jt) == 7) begin
                        exp_test[exp_count] = t;
                        exp_rec[exp_count].pc = a[15:0];
                        exp_rec[exp_count].rf_we = we[0];
                        exp_rec[exp_count].rd = rd[3:0];
                        exp_rec[exp_count].value = w[15:0];
                        exp_rec[exp_count].flags = cpu_pkg::flags_t'(fl[3:0]);
                        exp_rec[exp_count].jump_taken = jt[0];
                        exp_count++;
                    end
                end
            end
            $fclose(fd);
            cycles = 0;
            while (!chk_done && cycles < RUN_LIMIT) begin
                @(posedge clk);
                cycles++;
            end
            if (!chk_done) begin
                $display("checker did not finish within %0d cycles", RUN_LIMIT);
                $display("SIMULATION FAILED");
            end else if (chk_errors == 0 && exp_count > 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/cpu_stimulus.mem
# P addr word : program word {imm, instr_l} at a word address, all hex
# E test pc rf_we rd value flags(zcnv) jump_taken : expected retire, test in decimal, rest hex
P 00 12340084
P 01 00FF0104
P 02 00020987
P 03 0001120A
P 04 00020A93
P 05 00020B14
P 06 00010B95
P 07 00041423
P 08 000124A5
P 09 00001527
P 0A 00080DA4
P 0B FFFF0084
P 0C 00010908
P 0D 00021189
P 0E 0003120A
P 0F 00031A8B
P 10 0003180C
P 11 7FFF080D
P 12 0002181B
P 13 0003080C
P 14 0040008E
P 15 0018028E
P 16 DEAD0604
P 17 BEEF0604
P 18 001B020E
P 19 DEAD0604
P 1A BEEF0604
P 1B 0040038E
P 1C 0040040E
P 1D 001F000E
P 1E DEAD0604
P 1F 0022068F
P 20 DEAD0604
P 21 DEAD0604
P 22 00006F01
P 23 00100084
P 24 00100888
P 25 00100888
P 26 00100888
P 27 0029000E
P 28 DEAD0604
P 29 00100888
P 2A 00FF0918
P 2B 0051080D
P 2C 123401FF
P 2D 00000000
P 2E 002E000E
E 1 00 1 1 1234 0 0
E 1 01 1 2 00FF 0 0
E 1 02 1 3 1333 0 0
E 1 03 1 4 EECB 6 0
E 1 04 1 5 0034 0 0
E 1 05 1 6 12FF 0 0
E 1 06 1 7 0000 8 0
E 1 07 1 8 0FF0 0 0
E 1 08 1 9 FEEC 2 0
E 1 09 1 A FFFF 2 0
E 1 0A 1 B 0012 0 0
E 2 0B 1 1 FFFF 0 0
E 2 0C 1 2 0000 C 0
E 2 0D 1 3 0001 0 0
E 2 0E 1 4 FFFF 6 0
E 2 0F 1 5 FFFF 6 0
E 2 10 0 0 0000 8 0
E 2 11 0 0 8000 2 0
E 2 12 0 0 0000 8 0
E 3 13 0 0 FFFE 2 0
E 3 14 0 0 0040 2 0
E 3 15 0 0 0018 2 1
E 3 18 0 0 001B 2 1
E 3 1B 0 0 0040 2 0
E 3 1C 0 0 0040 2 0
E 3 1D 0 0 001F 2 1
E 4 1F 1 D 0020 2 1
E 4 22 1 E 0020 2 0
E 5 23 1 1 0010 2 0
E 5 24 1 1 0020 0 0
E 5 25 1 1 0030 0 0
E 5 26 1 1 0040 0 0
E 5 27 0 0 0029 0 1
E 5 29 1 1 0050 0 0
E 5 2A 1 2 00AF 0 0
E 6 2B 0 0 FFFF 6 0
E 6 2C 0 0 0000 6 0
E 6 2D 0 0 0000 6 0

// File: compile.f
common/cpu_pkg.sv
src/alu.sv
src/reg_file.sv
fetch/fetch.sv
decode/decode.sv
execute/execute.sv
src/cpu_core.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_cpu_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu_core
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
